// File: test/mem_port_trace.txt
// Columns in hex: port _ we _ addr _ wdata _ region (f = no event) _ reader stall
// The stall delays the request pop whose index equals the line number
0_1_10000000_a5a50001_0_28
1_0_80000000_00000000_1_00
0_0_0fffffff_00000000_f_01
1_1_87fffffc_1234abcd_1_02
0_1_20000000_cafe0003_f_00
1_1_1fffffff_0badf00d_0_03
0_0_80001000_00000000_1_00
1_0_88000000_00000000_f_01
0_1_12345678_600dbeef_0_02
1_1_00000040_feedface_f_00
0_0_87000000_00000000_1_01
1_1_10000004_31415926_0_00

// File: build.f
+incdir+design
design/mem_port_pkg.sv
design/port_req_if.sv
design/port_frontend.sv
design/req_arbiter.sv
design/gray_fifo_src.sv
design/mem_port_top.sv
test/tb_clock_gen.sv
test/tb_mem_port_top.sv

// File: Makefile
# Verilator build and run of the memory-port bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_port_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_mem_port_top.sv
/* Testbench of the memory-port bridge: trace-driven requesters, async FIFO
   reader models, LFSR gaps and a watchdog */
`timescale 1ns/10ps
`include "mem_port_settings.svh"

module tb_mem_port_top;

  localparam int          NP         = `MP_NUM_PORTS;
  localparam int          DEPTH      = 1 << `MP_LOG_DEPTH;
  localparam int          TRACE_LEN  = 12;
  localparam int          LONG_STALL = 32;
  localparam logic [31:0] LFSR_SEED  = 32'd91408;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

  typedef logic [`MP_LOG_DEPTH:0] ptr_t;

  // Trace fields are port 83:80, we 79:76, addr 75:44, wdata 43:12, region 11:8, stall 7:0
  logic [83:0]                              trace_mem [TRACE_LEN];
  logic                                     clk, arst_n, readers_on;
  logic [NP-1:0]                            req, ack, we;
  logic [NP-1:0][`MP_ADDR_W-1:0]            addr;
  logic [NP-1:0][`MP_DATA_W-1:0]            wdata;
  ptr_t                                     req_wptr, req_rptr;
  mem_port_pkg::req_payload_t [DEPTH-1:0]   req_data;
  logic [NP-1:0][`MP_LOG_DEPTH:0]           evt_wptr, evt_rptr;
  mem_port_pkg::event_t [NP-1:0][DEPTH-1:0] evt_data;
  logic [31:0]                              lfsr_q [NP];
  int                                       exp_req [NP][$];
  int                                       exp_evt [NP][$];
  int                                       req_seen, evt_seen, evt_total;

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(10)) i_clock_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  mem_port_top i_mem_port_top (
    .clk_i      ( clk      ),
    .arst_n_i   ( arst_n   ),
    .req_i      ( req      ),
    .ack_o      ( ack      ),
    .addr_i     ( addr     ),
    .wdata_i    ( wdata    ),
    .we_i       ( we       ),
    .req_wptr_o ( req_wptr ),
    .req_data_o ( req_data ),
    .req_rptr_i ( req_rptr ),
    .evt_wptr_o ( evt_wptr ),
    .evt_data_o ( evt_data ),
    .evt_rptr_i ( evt_rptr )
  );

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int trace_port(int k);
    return int'(trace_mem[k][83:80]);
  endfunction

  function automatic int stall_of(int k);
    return int'(trace_mem[k][7:0]);
  endfunction

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic ptr_t gray2bin(ptr_t g);
    ptr_t b;
    b[`MP_LOG_DEPTH] = g[`MP_LOG_DEPTH];
    for (int i = `MP_LOG_DEPTH - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int p, input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsr_q[p][0]);
      lfsr_q[p] = lfsr_step(lfsr_q[p]);
    end
  endtask

  // Four-phase requester for one port
  task automatic run_port(input int p);
    int gap;
    for (int k = 0; k < TRACE_LEN; k++) begin
      if (trace_port(k) == p) begin
        take_bits(p, 2, gap);
        repeat (gap) @(negedge clk);
        addr[p]  = trace_mem[k][75:44];
        wdata[p] = trace_mem[k][43:12];
        we[p]    = trace_mem[k][76];
        req[p]   = 1'b1;
        do @(negedge clk); while (!ack[p]);
        req[p] = 1'b0;
        @(negedge clk);
        check_equal(64'(ack[p]), 64'd0, $sformatf("ack of port %0d after req drop", p));
      end
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin : p_main
    req        = '0;
    we         = '0;
    addr       = '0;
    wdata      = '0;
    readers_on = 1'b0;
    evt_total  = 0;
    for (int p = 0; p < NP; p++) begin
      lfsr_q[p] = LFSR_SEED;
    end
    $readmemh("test/mem_port_trace.txt", trace_mem);
    for (int k = 0; k < TRACE_LEN; k++) begin
      exp_req[trace_port(k)].push_back(k);
      if (trace_mem[k][11:8] != 4'hf) begin
        exp_evt[trace_port(k)].push_back(k);
        evt_total++;
      end
    end
    wait (arst_n);
    @(negedge clk);
    check_equal(64'(ack), 64'd0, "ack after reset");
    check_equal(64'(req_wptr), 64'd0, "request wptr after reset");
    check_equal(64'(evt_wptr), 64'd0, "event wptr after reset");
    readers_on = 1'b1;
    // Both ports run at once
    for (int p = 0; p < NP; p++) begin
      fork
        automatic int pp = p;
        run_port(pp);
      join_none
    end
    wait fork;
    wait (req_seen == TRACE_LEN && evt_seen == evt_total);
    repeat (20) @(negedge clk);
    check_equal(64'(req_wptr), 64'(req_rptr), "extra request after the trace");
    check_equal(64'(evt_wptr), 64'(evt_rptr), "extra event after the trace");
    $display("all tests passed");
    $finish;
  end

  // ------------------------------
  // FIFO reader models
  // ------------------------------
  initial begin : p_readers
    ptr_t                       rbin;
    ptr_t                       ebin [NP];
    int                         req_next [NP];
    int                         evt_next [NP];
    int                         stall_left, k;
    mem_port_pkg::req_payload_t r;
    mem_port_pkg::event_t       e;
    req_rptr = '0;
    evt_rptr = '0;
    rbin     = '0;
    req_seen = 0;
    evt_seen = 0;
    for (int p = 0; p < NP; p++) begin
      ebin[p]     = '0;
      req_next[p] = 0;
      evt_next[p] = 0;
    end
    wait (readers_on);
    stall_left = stall_of(0);
    forever begin
      @(negedge clk);
      if (stall_left > 0) begin
        // The pipeline must be backed up at the end of a long stall
        if (stall_left == 1 && stall_of(req_seen) >= LONG_STALL) begin
          check_equal(64'(ptr_t'(gray2bin(req_wptr) - rbin)), 64'(DEPTH),
                      "request FIFO fill level during reader stall");
          check_equal(64'(ack), 64'd0, "ack while the reader stalls");
        end
        stall_left--;
      end else begin
        if (req_wptr != req_rptr) begin
          r = req_data[rbin[`MP_LOG_DEPTH-1:0]];
          check_equal(64'(req_next[r.port] < exp_req[r.port].size()), 64'd1,
                      "request from a port with nothing pending");
          k = exp_req[r.port][req_next[r.port]];
          check_equal(64'(r.addr), 64'(trace_mem[k][75:44]), "request addr");
          check_equal(64'(r.wdata), 64'(trace_mem[k][43:12]), "request wdata");
          check_equal(64'(r.we), 64'(trace_mem[k][76]), "request we");
          req_next[r.port]++;
          rbin     = rbin + ptr_t'(1);
          req_rptr = rbin ^ (rbin >> 1);
          req_seen++;
          if (req_seen < TRACE_LEN) stall_left = stall_of(req_seen);
        end
        for (int p = 0; p < NP; p++) begin
          if (evt_wptr[p] != evt_rptr[p]) begin
            e = evt_data[p][ebin[p][`MP_LOG_DEPTH-1:0]];
            check_equal(64'(evt_next[p] < exp_evt[p].size()), 64'd1,
                        $sformatf("unexpected event on port %0d", p));
            k = exp_evt[p][evt_next[p]];
            check_equal(64'(e.port), 64'(p), "event port");
            check_equal(64'(e.region), 64'(trace_mem[k][8]), "event region");
            check_equal(64'(e.we), 64'(trace_mem[k][76]), "event we");
            evt_next[p]++;
            ebin[p]     = ebin[p] + ptr_t'(1);
            evt_rptr[p] = ebin[p] ^ (ebin[p] >> 1);
            evt_seen++;
          end
        end
      end
    end
  end

  // Watchdog sized by the trace length
  initial begin : p_watchdog
    repeat (TRACE_LEN * 200) @(posedge clk);
    $display("Timeout after %0d cycles, requests or events never arrived", TRACE_LEN * 200);
    $display("tests failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

// File: test/tb_clock_gen.sv
/* Testbench clock and reset generator */
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a falling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: design/mem_port_top.sv
/* Memory-port bridge top: port front ends, round-robin arbiter and
   async FIFO sources for the request stream and per-port events */
`timescale 1ns/10ps
`include "mem_port_settings.svh"

module mem_port_top (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  // Four-phase req/ack requester ports
  input  logic [`MP_NUM_PORTS-1:0]                  req_i,
  output logic [`MP_NUM_PORTS-1:0]                  ack_o,
  input  logic [`MP_NUM_PORTS-1:0][`MP_ADDR_W-1:0]  addr_i,
  input  logic [`MP_NUM_PORTS-1:0][`MP_DATA_W-1:0]  wdata_i,
  input  logic [`MP_NUM_PORTS-1:0]                  we_i,
  // Request channel toward the other clock domain
  output logic [`MP_LOG_DEPTH:0]                    req_wptr_o,
  output mem_port_pkg::req_payload_t [(1 << `MP_LOG_DEPTH)-1:0] req_data_o,
  input  logic [`MP_LOG_DEPTH:0]                    req_rptr_i,
  // Access monitor events in one channel per port
  output logic [`MP_NUM_PORTS-1:0][`MP_LOG_DEPTH:0] evt_wptr_o,
  output mem_port_pkg::event_t [`MP_NUM_PORTS-1:0][(1 << `MP_LOG_DEPTH)-1:0] evt_data_o,
  input  logic [`MP_NUM_PORTS-1:0][`MP_LOG_DEPTH:0] evt_rptr_i
);

  port_req_if req_if [`MP_NUM_PORTS] ();

  logic [`MP_NUM_PORTS-1:0]                   evt_valid;
  logic [`MP_NUM_PORTS-1:0]                   evt_ready;
  mem_port_pkg::event_t [`MP_NUM_PORTS-1:0]   evt;
  logic                                       arb_valid, arb_ready;
  mem_port_pkg::req_payload_t                 arb_out;

  // ------------------------------
  // Per-port front end and event FIFO
  // ------------------------------
  for (genvar i = 0; i < `MP_NUM_PORTS; i++) begin : g_port
    port_frontend i_frontend (
      .clk_i       ( clk_i                          ),
      .arst_n_i    ( arst_n_i                       ),
      .port_idx_i  ( mem_port_pkg::port_id_t'(i)    ),
      .req_i       ( req_i[i]                       ),
      .ack_o       ( ack_o[i]                       ),
      .addr_i      ( addr_i[i]                      ),
      .wdata_i     ( wdata_i[i]                     ),
      .we_i        ( we_i[i]                        ),
      .req         ( req_if[i]                      ),
      .evt_valid_o ( evt_valid[i]                   ),
      .evt_ready_i ( evt_ready[i]                   ),
      .evt_o       ( evt[i]                         )
    );

    gray_fifo_src #(
      .T            ( mem_port_pkg::event_t ),
      .LOG_DEPTH    ( `MP_LOG_DEPTH         )
    ) i_evt_fifo (
      .clk_i        ( clk_i         ),
      .arst_n_i     ( arst_n_i      ),
      .valid_i      ( evt_valid[i]  ),
      .ready_o      ( evt_ready[i]  ),
      .data_i       ( evt[i]        ),
      .async_data_o ( evt_data_o[i] ),
      .async_wptr_o ( evt_wptr_o[i] ),
      .async_rptr_i ( evt_rptr_i[i] )
    );
  end

  // ------------------------------
  // Merged request stream
  // ------------------------------
  req_arbiter i_arbiter (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .ports       ( req_if    ),
    .out_valid_o ( arb_valid ),
    .out_ready_i ( arb_ready ),
    .out_o       ( arb_out   )
  );

  gray_fifo_src #(
    .T            ( mem_port_pkg::req_payload_t ),
    .LOG_DEPTH    ( `MP_LOG_DEPTH               )
  ) i_req_fifo (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .valid_i      ( arb_valid  ),
    .ready_o      ( arb_ready  ),
    .data_i       ( arb_out    ),
    .async_data_o ( req_data_o ),
    .async_wptr_o ( req_wptr_o ),
    .async_rptr_i ( req_rptr_i )
  );

endmodule

// File: design/gray_fifo_src.sv
/* Source half of a gray-pointer async FIFO with read-pointer synchronizer */
`timescale 1ns/10ps
`include "mem_port_settings.svh"

module gray_fifo_src #(
  parameter type T         = logic,
  parameter int  LOG_DEPTH = 1
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  input  T                          data_i,
  output T [(2**LOG_DEPTH)-1:0]     async_data_o,
  output logic [LOG_DEPTH:0]        async_wptr_o,
  input  logic [LOG_DEPTH:0]        async_rptr_i
);

  localparam int DEPTH = 2**LOG_DEPTH;

  typedef logic [LOG_DEPTH:0] ptr_t;

  // Full when the two top gray bits differ and the rest match
  localparam ptr_t FULL_MASK = ptr_t'(3) << (LOG_DEPTH - 1);

  T [DEPTH-1:0]  mem_q;
  ptr_t          wptr_bin_q, wptr_gray_q;
  ptr_t          wptr_bin_d;
  ptr_t          rptr_sync_q [`MP_SYNC_STAGES];
  logic          full, write;

  function automatic ptr_t bin2gray(ptr_t b);
    return b ^ (b >> 1);
  endfunction

  assign full       = (wptr_gray_q == (rptr_sync_q[`MP_SYNC_STAGES-1] ^ FULL_MASK));
  assign ready_o    = !full;
  assign write      = valid_i && !full;
  assign wptr_bin_d = wptr_bin_q + ptr_t'(1);

  // ------------------------------
  // Write side
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else if (write) begin
      wptr_bin_q  <= wptr_bin_d;
      wptr_gray_q <= bin2gray(wptr_bin_d);
    end
  end

  always_ff @(posedge clk_i) begin
    if (write) begin
      mem_q[wptr_bin_q[LOG_DEPTH-1:0]] <= data_i;
    end
  end

  // Read pointer from the other domain
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < `MP_SYNC_STAGES; s++) begin
        rptr_sync_q[s] <= '0;
      end
    end else begin
      rptr_sync_q[0] <= async_rptr_i;
      for (int s = 1; s < `MP_SYNC_STAGES; s++) begin
        rptr_sync_q[s] <= rptr_sync_q[s-1];
      end
    end
  end

  assign async_data_o = mem_q;
  assign async_wptr_o = wptr_gray_q;

  a_gray_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    1'b1 |=> $countones(wptr_gray_q ^ $past(wptr_gray_q)) <= 1);

  a_no_write_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    full |=> $stable(wptr_gray_q));

endmodule

// File: design/req_arbiter.sv
/* Round-robin request arbiter with port tagging and an output cut register */
`timescale 1ns/10ps
`include "mem_port_settings.svh"

module req_arbiter (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  port_req_if.dst                      ports [`MP_NUM_PORTS],
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output mem_port_pkg::req_payload_t   out_o
);

  localparam int NP = `MP_NUM_PORTS;

  logic [NP-1:0]                        valid_a;
  logic [NP-1:0][`MP_ADDR_W-1:0]        addr_a;
  logic [NP-1:0][`MP_DATA_W-1:0]        wdata_a;
  logic [NP-1:0]                        we_a;
  logic [NP-1:0]                        grant;
  logic                                 accept;
  mem_port_pkg::port_id_t               last_q, win_idx;
  logic                                 out_valid_q;
  mem_port_pkg::req_payload_t           out_q;

  // Flatten the interface array
  for (genvar i = 0; i < NP; i++) begin : g_port
    assign valid_a[i]     = ports[i].valid;
    assign addr_a[i]      = ports[i].addr;
    assign wdata_a[i]     = ports[i].wdata;
    assign we_a[i]        = ports[i].we;
    assign ports[i].ready = grant[i] && accept;
  end

  // ------------------------------
  // Round-robin grant
  // ------------------------------
  // Search starts one past the last winner
  always_comb begin : p_grant
    logic found;
    int   idx;
    grant   = '0;
    win_idx = last_q;
    found   = 1'b0;
    for (int k = 1; k <= NP; k++) begin
      idx = (int'(last_q) + k) % NP;
      if (!found && valid_a[idx]) begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        win_idx    = mem_port_pkg::port_id_t'(idx);
      end
    end
  end

  // Cut stage takes a new item while the old one drains
  assign accept = !out_valid_q || out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_q <= 1'b0;
      last_q      <= '0;
    end else if (|grant && accept) begin
      out_valid_q <= 1'b1;
      last_q      <= win_idx;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (|grant && accept) begin
      out_q.addr  <= addr_a[win_idx];
      out_q.wdata <= wdata_a[win_idx];
      out_q.we    <= we_a[win_idx];
      out_q.port  <= win_idx;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_o       = out_q;

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(grant));

endmodule

// File: design/port_frontend.sv
/* Four-phase req/ack port adapter with region check and event generation */
`timescale 1ns/10ps
`include "mem_port_settings.svh"

module port_frontend (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  mem_port_pkg::port_id_t   port_idx_i,
  input  logic                     req_i,
  output logic                     ack_o,
  input  logic [`MP_ADDR_W-1:0]    addr_i,
  input  logic [`MP_DATA_W-1:0]    wdata_i,
  input  logic                     we_i,
  port_req_if.src                  req,
  output logic                     evt_valid_o,
  input  logic                     evt_ready_i,
  output mem_port_pkg::event_t     evt_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PEND,
    ST_ACKED
  } state_t;

  state_t                  state_q;
  logic                    req_valid_q, evt_valid_q;
  logic                    hit_r0, hit_r1, capture;
  logic                    req_left, evt_left;
  logic [`MP_ADDR_W-1:0]   addr_q;
  logic [`MP_DATA_W-1:0]   wdata_q;
  logic                    we_q;
  mem_port_pkg::event_t    evt_d, evt_q;

  // Region check against the two address rules
  assign hit_r0 = (addr_i >= `MP_R0_BASE) && (addr_i < `MP_R0_END);
  assign hit_r1 = (addr_i >= `MP_R1_BASE) && (addr_i < `MP_R1_END);

  always_comb begin
    evt_d.port   = port_idx_i;
    evt_d.region = hit_r1 ? mem_port_pkg::REGION_1 : mem_port_pkg::REGION_0;
    evt_d.we     = we_i;
  end

  assign capture  = (state_q == ST_IDLE) && req_i;
  // Still waiting after this edge
  assign req_left = req_valid_q && !req.ready;
  assign evt_left = evt_valid_q && !evt_ready_i;

  // ------------------------------
  // Handshake FSM
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= ST_IDLE;
      req_valid_q <= 1'b0;
      evt_valid_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            state_q     <= ST_PEND;
            req_valid_q <= 1'b1;
            evt_valid_q <= hit_r0 || hit_r1;
          end
        end
        ST_PEND: begin
          if (!req_left) req_valid_q <= 1'b0;
          if (!evt_left) evt_valid_q <= 1'b0;
          // Ack only once both request and event are gone
          if (!req_left && !evt_left) state_q <= ST_ACKED;
        end
        ST_ACKED: begin
          if (!req_i) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Payload held until taken
  always_ff @(posedge clk_i) begin
    if (capture) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      we_q    <= we_i;
      evt_q   <= evt_d;
    end
  end

  assign ack_o       = (state_q == ST_ACKED);
  assign req.valid   = req_valid_q;
  assign req.addr    = addr_q;
  assign req.wdata   = wdata_q;
  assign req.we      = we_q;
  assign evt_valid_o = evt_valid_q;
  assign evt_o       = evt_q;

  a_addr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req.valid && !req.ready |=> $stable(req.addr));

endmodule

// File: design/port_req_if.sv
/* Valid/ready request link between a port front end and the arbiter */
`timescale 1ns/10ps
`include "mem_port_settings.svh"

interface port_req_if;

  logic                  valid;
  logic                  ready;
  logic [`MP_ADDR_W-1:0] addr;
  logic [`MP_DATA_W-1:0] wdata;
  logic                  we;

  // Front end side
  modport src (
    output valid, addr, wdata, we,
    input  ready
  );

  // Arbiter side
  modport dst (
    input  valid, addr, wdata, we,
    output ready
  );

endinterface

// File: design/mem_port_pkg.sv
/* Shared types of the memory-port bridge: port index, request payload,
   region encoding and monitor event */
`include "mem_port_settings.svh"

package mem_port_pkg;

  // ------------------------------
  // Requester identification
  // ------------------------------
  typedef logic [$clog2(`MP_NUM_PORTS)-1:0] port_id_t;

  // ------------------------------
  // Outgoing request
  // ------------------------------
  // Port tag sits in the low bits so the reader can split per port
  typedef struct packed {
    logic [`MP_ADDR_W-1:0] addr;
    logic [`MP_DATA_W-1:0] wdata;
    logic                  we;
    port_id_t              port;
  } req_payload_t;

  // ------------------------------
  // Access monitor
  // ------------------------------
  // Which address rule matched
  typedef enum logic {
    REGION_0 = 1'b0,
    REGION_1 = 1'b1
  } region_t;

  // One event per region hit
  typedef struct packed {
    port_id_t port;
    region_t  region;
    logic     we;
  } event_t;

endpackage

// File: design/mem_port_settings.svh
/* Global settings of the memory-port bridge: port count, widths,
   async FIFO depth, synchronizer depth and address-rule bounds */
`ifndef MEM_PORT_SETTINGS_SVH
`define MEM_PORT_SETTINGS_SVH

// Requester ports
`define MP_NUM_PORTS 2

// Payload widths
`define MP_ADDR_W 32
`define MP_DATA_W 32

// Async FIFO geometry with depth 2**MP_LOG_DEPTH
`define MP_LOG_DEPTH   1
`define MP_SYNC_STAGES 2

// Address rules with inclusive base and exclusive end
`define MP_R0_BASE 32'h1000_0000
`define MP_R0_END  32'h2000_0000
`define MP_R1_BASE 32'h8000_0000
`define MP_R1_END  32'h8800_0000

`endif
